/* logic/llc_params.svh */
// ------------------------------
// LLC sizes
// Tag, set, way and line widths
// ------------------------------
`ifndef LLC_PARAMS_SVH
`define LLC_PARAMS_SVH

// Tag bits above the set index
`define LLC_TAG_BITS 8

// Set index bits, 16 sets
`define LLC_SET_BITS 4

// Associativity
`define LLC_WAYS 4

// Full line width
`define LLC_LINE_BITS 128

// Derived sizes
`define LLC_SETS (1 << `LLC_SET_BITS)
`define LLC_WAY_BITS $clog2(`LLC_WAYS)
`define LLC_ADDR_BITS (`LLC_TAG_BITS + `LLC_SET_BITS)

`endif

/* logic/llc_pkg.sv */
// ------------------------------
// LLC types
// Field types and channel structs
// ------------------------------
`include "llc_params.svh"

package llc_pkg;

    typedef enum logic {
        READ  = 1'b0,
        WRITE = 1'b1
    } llc_op_t;

    typedef enum logic [1:0] {
        INVALID = 2'b00,
        VALID   = 2'b01,
        DIRTY   = 2'b10
    } llc_state_t;

    typedef logic [`LLC_TAG_BITS-1:0]  llc_tag_t;
    typedef logic [`LLC_SET_BITS-1:0]  llc_set_t;
    typedef logic [`LLC_WAY_BITS-1:0]  llc_way_t;
    typedef logic [`LLC_LINE_BITS-1:0] line_t;

    // Tag in the upper bits, set index below
    typedef struct packed {
        llc_tag_t tag;
        llc_set_t set;
    } line_addr_t;

    typedef struct packed {
        llc_op_t    op;
        line_addr_t addr;
        line_t      line;
    } llc_req_in_t;

    typedef struct packed {
        line_addr_t addr;
        line_t      line;
    } llc_rsp_out_t;

    typedef struct packed {
        llc_op_t    op;
        line_addr_t addr;
        line_t      line;
    } llc_mem_req_t;

    typedef struct packed {
        line_t line;
    } llc_mem_rsp_t;

    // One way of a set
    typedef struct packed {
        llc_tag_t   tag;
        llc_state_t state;
        line_t      line;
    } llc_set_entry_t;

endpackage

/* logic/llc_localmem.sv */
// ------------------------------
// LLC local memory
// Set arrays with registered read
// ------------------------------
`timescale 1ns/1ps
`include "llc_params.svh"

module llc_localmem (
    input  logic                                   clk,
    input  logic                                   rst,
    input  llc_pkg::llc_set_t                      rd_set_i,
    input  logic                                   rd_en_i,
    input  logic                                   wr_en_i,
    input  llc_pkg::llc_way_t                      wr_way_i,
    input  llc_pkg::llc_set_entry_t                wr_entry_i,
    input  logic                                   incr_evict_i,
    output llc_pkg::llc_set_entry_t [`LLC_WAYS-1:0] rd_entries_o,
    output llc_pkg::llc_way_t                      rd_evict_way_o
);

    import llc_pkg::*;

    llc_tag_t   tags_mem   [`LLC_SETS][`LLC_WAYS];
    line_t      lines_mem  [`LLC_SETS][`LLC_WAYS];
    llc_state_t states_mem [`LLC_SETS][`LLC_WAYS];
    llc_way_t   evict_ptr  [`LLC_SETS];

    // States and evict pointers come up cleared
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < `LLC_SETS; s++) begin
                evict_ptr[s] <= '0;
                for (int w = 0; w < `LLC_WAYS; w++) begin
                    states_mem[s][w] <= INVALID;
                end
            end
        end else begin
            if (wr_en_i) begin
                states_mem[rd_set_i][wr_way_i] <= wr_entry_i.state;
            end
            if (incr_evict_i) begin
                if (evict_ptr[rd_set_i] == llc_way_t'(`LLC_WAYS - 1)) begin
                    evict_ptr[rd_set_i] <= '0;
                end else begin
                    evict_ptr[rd_set_i] <= evict_ptr[rd_set_i] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tags_mem[rd_set_i][wr_way_i]  <= wr_entry_i.tag;
            lines_mem[rd_set_i][wr_way_i] <= wr_entry_i.line;
        end
    end

    // Whole set read out in one cycle
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            for (int w = 0; w < `LLC_WAYS; w++) begin
                rd_entries_o[w].tag   <= tags_mem[rd_set_i][w];
                rd_entries_o[w].state <= states_mem[rd_set_i][w];
                rd_entries_o[w].line  <= lines_mem[rd_set_i][w];
            end
            rd_evict_way_o <= evict_ptr[rd_set_i];
        end
    end

endmodule

/* logic/llc_lookup_way.sv */
// ------------------------------
// LLC way lookup
// Hit way and victim selection
// ------------------------------
`timescale 1ns/1ps
`include "llc_params.svh"

module llc_lookup_way (
    input  llc_pkg::llc_tag_t                      tag_i,
    input  llc_pkg::llc_set_t                      set_i,
    input  llc_pkg::llc_set_entry_t [`LLC_WAYS-1:0] entries_i,
    input  llc_pkg::llc_way_t                      evict_way_i,
    output logic                                   hit_o,
    output llc_pkg::llc_way_t                      hit_way_o,
    output llc_pkg::llc_way_t                      victim_way_o,
    output logic                                   victim_dirty_o,
    output llc_pkg::line_addr_t                    victim_addr_o
);

    import llc_pkg::*;

    logic     has_invalid;
    llc_way_t invalid_way;
    llc_way_t vway;

    always_comb begin
        hit_o       = 1'b0;
        hit_way_o   = '0;
        has_invalid = 1'b0;
        invalid_way = '0;
        // Scan downwards so the lowest way wins
        for (int w = `LLC_WAYS - 1; w >= 0; w--) begin
            if (entries_i[w].state != INVALID && entries_i[w].tag == tag_i) begin
                hit_o     = 1'b1;
                hit_way_o = llc_way_t'(w);
            end
            if (entries_i[w].state == INVALID) begin
                has_invalid = 1'b1;
                invalid_way = llc_way_t'(w);
            end
        end
    end

    // Free way first, else round-robin pointer
    always_comb begin
        vway               = has_invalid ? invalid_way : evict_way_i;
        victim_way_o       = vway;
        victim_dirty_o     = (entries_i[vway].state == DIRTY);
        victim_addr_o.tag  = entries_i[vway].tag;
        victim_addr_o.set  = set_i;
    end

endmodule

/* logic/llc_process_request.sv */
// ------------------------------
// LLC request processing
// Miss traffic, response, update
// ------------------------------
`timescale 1ns/1ps

module llc_process_request (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start_i,
    input  llc_pkg::llc_req_in_t    req_i,
    input  logic                    hit_i,
    input  llc_pkg::llc_way_t       hit_way_i,
    input  llc_pkg::line_t          hit_line_i,
    input  llc_pkg::llc_way_t       victim_way_i,
    input  logic                    victim_dirty_i,
    input  llc_pkg::line_addr_t     victim_addr_i,
    input  llc_pkg::line_t          victim_line_i,
    input  logic                    update_i,
    output logic                    mem_req_valid_o,
    input  logic                    mem_req_ready_i,
    output llc_pkg::llc_mem_req_t   mem_req_o,
    input  logic                    mem_rsp_valid_i,
    output logic                    mem_rsp_ready_o,
    input  llc_pkg::llc_mem_rsp_t   mem_rsp_i,
    output logic                    rsp_valid_o,
    input  logic                    rsp_ready_i,
    output llc_pkg::llc_rsp_out_t   rsp_o,
    output logic                    done_o,
    output logic                    wr_en_o,
    output llc_pkg::llc_way_t       wr_way_o,
    output llc_pkg::llc_set_entry_t wr_entry_o,
    output logic                    incr_evict_o
);

    import llc_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        WRITEBACK,
        FETCH_REQ,
        FETCH_RSP,
        RESPOND
    } proc_state_t;

    proc_state_t state, next_state;
    line_t       fetch_line_q;
    line_t       rsp_line;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (start_i) begin
                    if (hit_i) begin
                        next_state = RESPOND;
                    end else if (victim_dirty_i) begin
                        next_state = WRITEBACK;
                    end else if (req_i.op == READ) begin
                        next_state = FETCH_REQ;
                    end else begin
                        next_state = RESPOND;
                    end
                end
            end
            WRITEBACK: begin
                if (mem_req_ready_i) begin
                    next_state = (req_i.op == READ) ? FETCH_REQ : RESPOND;
                end
            end
            FETCH_REQ: begin
                if (mem_req_ready_i) begin
                    next_state = FETCH_RSP;
                end
            end
            FETCH_RSP: begin
                if (mem_rsp_valid_i) begin
                    next_state = RESPOND;
                end
            end
            RESPOND: begin
                if (rsp_ready_i) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == FETCH_RSP && mem_rsp_valid_i) begin
            fetch_line_q <= mem_rsp_i.line;
        end
    end

    // Writes return their own data
    always_comb begin
        if (req_i.op == WRITE) begin
            rsp_line = req_i.line;
        end else if (hit_i) begin
            rsp_line = hit_line_i;
        end else begin
            rsp_line = fetch_line_q;
        end
    end

    always_comb begin
        mem_req_valid_o = (state == WRITEBACK) || (state == FETCH_REQ);
        if (state == WRITEBACK) begin
            mem_req_o.op   = WRITE;
            mem_req_o.addr = victim_addr_i;
            mem_req_o.line = victim_line_i;
        end else begin
            mem_req_o.op   = READ;
            mem_req_o.addr = req_i.addr;
            mem_req_o.line = '0;
        end
    end

    assign mem_rsp_ready_o = (state == FETCH_RSP);

    assign rsp_valid_o = (state == RESPOND);
    assign rsp_o.addr  = req_i.addr;
    assign rsp_o.line  = rsp_line;
    assign done_o      = (state == RESPOND) && rsp_ready_i;

    // A read hit needs no array write
    assign wr_en_o          = update_i && !(hit_i && req_i.op == READ);
    assign wr_way_o         = hit_i ? hit_way_i : victim_way_i;
    assign wr_entry_o.tag   = req_i.addr.tag;
    assign wr_entry_o.state = (req_i.op == WRITE) ? DIRTY : VALID;
    assign wr_entry_o.line  = rsp_line;
    assign incr_evict_o     = update_i && !hit_i;

endmodule

/* logic/llc_core.sv */
// ------------------------------
// LLC core top level
// Request sequencing and blocks
// ------------------------------
`timescale 1ns/1ps
`include "llc_params.svh"

module llc_core (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  llc_req_in_valid_i,
    output logic                  llc_req_in_ready_o,
    input  llc_pkg::llc_req_in_t  llc_req_in_i,
    output logic                  llc_rsp_out_valid_o,
    input  logic                  llc_rsp_out_ready_i,
    output llc_pkg::llc_rsp_out_t llc_rsp_out_o,
    output logic                  llc_mem_req_valid_o,
    input  logic                  llc_mem_req_ready_i,
    output llc_pkg::llc_mem_req_t llc_mem_req_o,
    input  logic                  llc_mem_rsp_valid_i,
    output logic                  llc_mem_rsp_ready_o,
    input  llc_pkg::llc_mem_rsp_t llc_mem_rsp_i
);

    import llc_pkg::*;

    typedef enum logic [2:0] {
        DECODE,
        READ_SET,
        LOOKUP,
        PROCESS,
        UPDATE
    } core_state_t;

    core_state_t state, next_state;
    logic        process_done;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= DECODE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            DECODE:   if (llc_req_in_valid_i) next_state = READ_SET;
            READ_SET: next_state = LOOKUP;
            LOOKUP:   next_state = PROCESS;
            PROCESS:  if (process_done) next_state = UPDATE;
            UPDATE:   next_state = DECODE;
            default:  next_state = DECODE;
        endcase
    end

    logic decode_en, rd_set_en, lookup_en, update_en;
    assign decode_en = (state == DECODE);
    assign rd_set_en = (state == READ_SET);
    assign lookup_en = (state == LOOKUP);
    assign update_en = (state == UPDATE);

    assign llc_req_in_ready_o = decode_en;

    llc_req_in_t req_q;

    always_ff @(posedge clk) begin
        if (decode_en && llc_req_in_valid_i) begin
            req_q <= llc_req_in_i;
        end
    end

    llc_set_entry_t [`LLC_WAYS-1:0] rd_entries;
    llc_way_t       rd_evict_way;
    logic           hit, victim_dirty;
    llc_way_t       hit_way, victim_way;
    line_addr_t     victim_addr;
    logic           wr_en, incr_evict_req;
    llc_way_t       wr_way;
    llc_set_entry_t wr_entry;

    llc_localmem localmem_u (
        .clk            (clk),
        .rst            (rst),
        .rd_set_i       (req_q.addr.set),
        .rd_en_i        (rd_set_en),
        .wr_en_i        (wr_en),
        .wr_way_i       (wr_way),
        .wr_entry_i     (wr_entry),
        // Pointer moves only when its own way was taken
        .incr_evict_i   (incr_evict_req && (victim_way == rd_evict_way)),
        .rd_entries_o   (rd_entries),
        .rd_evict_way_o (rd_evict_way)
    );

    llc_lookup_way lookup_way_u (
        .tag_i          (req_q.addr.tag),
        .set_i          (req_q.addr.set),
        .entries_i      (rd_entries),
        .evict_way_i    (rd_evict_way),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_addr_o  (victim_addr)
    );

    llc_process_request process_request_u (
        .clk             (clk),
        .rst             (rst),
        .start_i         (lookup_en),
        .req_i           (req_q),
        .hit_i           (hit),
        .hit_way_i       (hit_way),
        .hit_line_i      (rd_entries[hit_way].line),
        .victim_way_i    (victim_way),
        .victim_dirty_i  (victim_dirty),
        .victim_addr_i   (victim_addr),
        .victim_line_i   (rd_entries[victim_way].line),
        .update_i        (update_en),
        .mem_req_valid_o (llc_mem_req_valid_o),
        .mem_req_ready_i (llc_mem_req_ready_i),
        .mem_req_o       (llc_mem_req_o),
        .mem_rsp_valid_i (llc_mem_rsp_valid_i),
        .mem_rsp_ready_o (llc_mem_rsp_ready_o),
        .mem_rsp_i       (llc_mem_rsp_i),
        .rsp_valid_o     (llc_rsp_out_valid_o),
        .rsp_ready_i     (llc_rsp_out_ready_i),
        .rsp_o           (llc_rsp_out_o),
        .done_o          (process_done),
        .wr_en_o         (wr_en),
        .wr_way_o        (wr_way),
        .wr_entry_o      (wr_entry),
        .incr_evict_o    (incr_evict_req)
    );

endmodule

/* sim/llc_tb.sv */
// ------------------------------
// LLC core testbench
// Memory model, reference cache, checks
// ------------------------------
`timescale 1ns/1ps
`include "llc_params.svh"

module llc_tb;

    import llc_pkg::*;

    logic           clk;
    logic           rst;
    logic           req_valid;
    logic           req_ready;
    llc_req_in_t    req;
    logic           rsp_valid;
    logic           rsp_ready;
    llc_rsp_out_t   rsp;
    logic           mem_req_valid;
    logic           mem_req_ready;
    llc_mem_req_t   mem_req;
    logic           mem_rsp_valid;
    logic           mem_rsp_ready;
    llc_mem_rsp_t   mem_rsp;

    // Test list read from the data file
    int         t_op   [$];
    line_addr_t t_addr [$];
    line_t      t_data [$];
    int         t_bp   [$];

    int   error_count = 0;
    int   tests_run = 0;
    int   tests_failed = 0;
    logic aborted = 1'b0;

    // Reference copy of the cache
    llc_tag_t   ref_tag   [`LLC_SETS][`LLC_WAYS];
    llc_state_t ref_state [`LLC_SETS][`LLC_WAYS];
    line_t      ref_line  [`LLC_SETS][`LLC_WAYS];
    int         ref_ptr   [`LLC_SETS];
    line_t      ref_mem   [int];

    logic       exp_hit;
    logic       exp_wb;
    logic       exp_fetch;
    line_addr_t exp_wb_addr;
    line_t      exp_wb_data;
    line_t      exp_line;

    // Memory model state and traffic counters
    line_t       mem_lines [int];
    int          wb_total = 0;
    int          fetch_total = 0;
    int          fetch_at_wb = 0;
    line_addr_t  wb_addr_last;
    line_t       wb_data_last;
    line_addr_t  fetch_addr_last;
    logic [31:0] lfsr_state = 32'h73c8_e643;

    llc_core i_llc_core (
        .clk                 (clk),
        .rst                 (rst),
        .llc_req_in_valid_i  (req_valid),
        .llc_req_in_ready_o  (req_ready),
        .llc_req_in_i        (req),
        .llc_rsp_out_valid_o (rsp_valid),
        .llc_rsp_out_ready_i (rsp_ready),
        .llc_rsp_out_o       (rsp),
        .llc_mem_req_valid_o (mem_req_valid),
        .llc_mem_req_ready_i (mem_req_ready),
        .llc_mem_req_o       (mem_req),
        .llc_mem_rsp_valid_i (mem_rsp_valid),
        .llc_mem_rsp_ready_o (mem_rsp_ready),
        .llc_mem_rsp_i       (mem_rsp)
    );

    always #10 clk = ~clk;

    task automatic check_value(input logic [159:0] actual, input logic [159:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s mismatch, got %0h, expected %0h",
                     $time, what, actual, expected);
            error_count++;
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    function automatic int addr_key(input line_addr_t addr);
        return {20'd0, addr};
    endfunction

    // Initial memory content tied to the full line address
    function automatic line_t addr_pattern(input line_addr_t addr);
        logic [11:0] a;
        line_t       p;
        a = addr;
        for (int i = 0; i < 4; i++) begin
            p[i*32 +: 32] = {4'(i), 4'hc, a, ~a};
        end
        return p;
    endfunction

    // Steps the reference cache and sets the expected traffic and data
    task automatic predict_request(input int op, input line_addr_t addr, input line_t data);
        int s;
        int way;
        int inv;
        s = int'(addr.set);
        way = 0;
        inv = -1;
        exp_hit = 1'b0;
        exp_wb = 1'b0;
        exp_fetch = 1'b0;
        for (int w = `LLC_WAYS - 1; w >= 0; w--) begin
            if (ref_state[s][w] != INVALID && ref_tag[s][w] == addr.tag) begin
                exp_hit = 1'b1;
                way = w;
            end
            if (ref_state[s][w] == INVALID) begin
                inv = w;
            end
        end
        if (exp_hit) begin
            if (op == 1) begin
                ref_line[s][way] = data;
                ref_state[s][way] = DIRTY;
            end
            exp_line = ref_line[s][way];
        end else begin
            way = (inv >= 0) ? inv : ref_ptr[s];
            if (ref_state[s][way] == DIRTY) begin
                exp_wb = 1'b1;
                exp_wb_addr.tag = ref_tag[s][way];
                exp_wb_addr.set = addr.set;
                exp_wb_data = ref_line[s][way];
                ref_mem[addr_key(exp_wb_addr)] = exp_wb_data;
            end
            if (op == 1) begin
                exp_line = data;
            end else begin
                exp_fetch = 1'b1;
                if (ref_mem.exists(addr_key(addr))) begin
                    exp_line = ref_mem[addr_key(addr)];
                end else begin
                    exp_line = addr_pattern(addr);
                end
            end
            if (way == ref_ptr[s]) begin
                ref_ptr[s] = (ref_ptr[s] + 1) % `LLC_WAYS;
            end
            ref_tag[s][way] = addr.tag;
            ref_state[s][way] = (op == 1) ? DIRTY : VALID;
            ref_line[s][way] = exp_line;
        end
    endtask

    task automatic load_tests;
        int         fd;
        int         n;
        int         op_v;
        int         bp_v;
        logic [11:0] addr_v;
        line_t      data_v;
        logic [31:0] word3;
        logic [31:0] word2;
        logic [31:0] word1;
        logic [31:0] word0;
        string      line_s;
        fd = $fopen("sim/llc_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test file sim/llc_tests.txt");
            aborted = 1'b1;
            return;
        end
        while (!$feof(fd)) begin
            line_s = "";
            void'($fgets(line_s, fd));
            if (line_s.len() == 0 || line_s[0] == "#") begin
                continue;
            end
            n = $sscanf(line_s, "%d %h %h %d", op_v, addr_v, data_v, bp_v);
            if (n <= 0) begin
                continue;
            end
            if (n != 4) begin
                // Write data may also be split into four 32-bit words
                n = $sscanf(line_s, "%d %h %h %h %h %h %d", op_v, addr_v,
                            word3, word2, word1, word0, bp_v);
                data_v = {word3, word2, word1, word0};
                if (n != 7) begin
                    $display("Malformed line in the test file: %s", line_s);
                    aborted = 1'b1;
                    break;
                end
            end
            t_op.push_back(op_v);
            t_addr.push_back(addr_v);
            t_data.push_back(data_v);
            t_bp.push_back(bp_v);
        end
        $fclose(fd);
    endtask

    task automatic drive_request(input int i);
        req_valid = 1'b1;
        req.op = (t_op[i] == 1) ? WRITE : READ;
        req.addr = t_addr[i];
        req.line = t_data[i];
    endtask

    task automatic run_tests;
        int           errors_before;
        int           wb0;
        int           f0;
        int           waited;
        int           stalled;
        logic         accepted;
        logic         got;
        llc_rsp_out_t rsp_seen;
        string        kind;
        string        op_name;
        for (int i = 0; i < t_op.size(); i++) begin
            if (!req_valid) begin
                drive_request(i);
            end
            accepted = 1'b0;
            waited = 0;
            while (!accepted && waited < 100) begin
                @(negedge clk);
                accepted = req_valid && req_ready;
                waited++;
            end
            if (!accepted) begin
                $display("Timeout: request %0d was not accepted within 100 cycles", i);
                aborted = 1'b1;
                break;
            end
            @(posedge clk);
            #1;
            predict_request(t_op[i], t_addr[i], t_data[i]);
            wb0 = wb_total;
            f0 = fetch_total;
            errors_before = error_count;
            // Next request waits on the bus while this one is in flight
            if (i + 1 < t_op.size()) begin
                drive_request(i + 1);
            end else begin
                req_valid = 1'b0;
            end
            rsp_ready = (t_bp[i] == 0);
            got = 1'b0;
            waited = 0;
            stalled = 0;
            while (!got && waited < 200) begin
                @(negedge clk);
                waited++;
                if (rsp_valid && rsp_ready) begin
                    got = 1'b1;
                    rsp_seen = rsp;
                end else if (rsp_valid) begin
                    stalled++;
                    if (stalled >= t_bp[i]) begin
                        @(posedge clk);
                        #1;
                        rsp_ready = 1'b1;
                    end
                end
            end
            if (!got) begin
                $display("Timeout: no response for request %0d within 200 cycles", i);
                aborted = 1'b1;
                break;
            end
            @(posedge clk);
            #1;
            rsp_ready = 1'b0;
            check_value(rsp_seen.addr, t_addr[i], "response address");
            check_value(rsp_seen.line, exp_line, "response line");
            check_value(wb_total - wb0, exp_wb, "write-back count");
            if (exp_wb) begin
                check_value(wb_addr_last, exp_wb_addr, "write-back address");
                check_value(wb_data_last, exp_wb_data, "write-back data");
                check_value(fetch_at_wb, f0, "fetch count before write-back");
            end
            check_value(fetch_total - f0, exp_fetch, "fetch count");
            if (exp_fetch) begin
                check_value(fetch_addr_last, t_addr[i], "fetch address");
            end
            tests_run++;
            kind = exp_hit ? "hit" : "miss";
            op_name = (t_op[i] == 1) ? "WRITE" : "READ";
            if (error_count == errors_before) begin
                $display("test %0d: %s %h %s ok", i, op_name, t_addr[i], kind);
            end else begin
                tests_failed++;
                $display("test %0d: %s %h %s failed", i, op_name, t_addr[i], kind);
            end
        end
    endtask

    // Fetch replies after a random delay and ready drops at random
    initial begin : memory_model
        logic         req_fire;
        logic         rsp_fire;
        logic         req_held;
        logic         fetch_pending;
        int           delay_left;
        int           r;
        line_t        fetch_data;
        llc_mem_req_t req_seen;
        llc_mem_req_t req_last;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp = '0;
        req_held = 1'b0;
        req_last = '0;
        fetch_pending = 1'b0;
        delay_left = 0;
        fetch_data = '0;
        forever begin
            @(negedge clk);
            if (req_held) begin
                check_value(mem_req_valid, 1'b1, "memory request valid under back-pressure");
                check_value(mem_req, req_last, "memory request payload under back-pressure");
            end
            if (mem_rsp_valid) begin
                check_value(mem_rsp_ready, 1'b1, "memory response ready with a line offered");
            end
            req_fire = mem_req_valid && mem_req_ready;
            rsp_fire = mem_rsp_valid && mem_rsp_ready;
            req_held = mem_req_valid && !mem_req_ready;
            req_seen = mem_req;
            req_last = mem_req;
            @(posedge clk);
            #1;
            if (req_fire) begin
                if (req_seen.op == WRITE) begin
                    mem_lines[addr_key(req_seen.addr)] = req_seen.line;
                    wb_total++;
                    wb_addr_last = req_seen.addr;
                    wb_data_last = req_seen.line;
                    fetch_at_wb = fetch_total;
                end else begin
                    fetch_total++;
                    fetch_addr_last = req_seen.addr;
                    if (mem_lines.exists(addr_key(req_seen.addr))) begin
                        fetch_data = mem_lines[addr_key(req_seen.addr)];
                    end else begin
                        fetch_data = addr_pattern(req_seen.addr);
                    end
                    random_bits(2, r);
                    delay_left = r;
                    fetch_pending = 1'b1;
                end
            end
            if (rsp_fire) begin
                mem_rsp_valid = 1'b0;
            end
            if (fetch_pending) begin
                if (delay_left == 0) begin
                    mem_rsp_valid = 1'b1;
                    mem_rsp.line = fetch_data;
                    fetch_pending = 1'b0;
                end else begin
                    delay_left--;
                end
            end
            // Ready low about one cycle in four
            random_bits(2, r);
            mem_req_ready = (r != 0);
        end
    end

    initial begin : handshake_monitor
        logic         pending;
        logic         rsp_held;
        llc_rsp_out_t rsp_last;
        pending = 1'b0;
        rsp_held = 1'b0;
        rsp_last = '0;
        forever begin
            @(negedge clk);
            if (req_ready && pending) begin
                check_value(req_ready, 1'b0, "request ready before the response transfer");
            end
            if (!pending) begin
                check_value(rsp_valid, 1'b0, "response valid with no request in flight");
                check_value(mem_req_valid, 1'b0, "memory request with no request in flight");
            end
            if (rsp_held) begin
                check_value(rsp_valid, 1'b1, "response valid under back-pressure");
                check_value(rsp, rsp_last, "response payload under back-pressure");
            end
            rsp_held = rsp_valid && !rsp_ready;
            rsp_last = rsp;
            if (req_valid && req_ready) begin
                pending = 1'b1;
            end else if (rsp_valid && rsp_ready) begin
                pending = 1'b0;
            end
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b0;
        req_valid = 1'b0;
        req = '0;
        rsp_ready = 1'b0;
        for (int s = 0; s < `LLC_SETS; s++) begin
            ref_ptr[s] = 0;
            for (int w = 0; w < `LLC_WAYS; w++) begin
                ref_tag[s][w] = '0;
                ref_state[s][w] = INVALID;
                ref_line[s][w] = '0;
            end
        end
        load_tests();
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b1;
        // A few idle cycles with nothing requested
        repeat (3) @(posedge clk);
        #1;
        if (!aborted) begin
            run_tests();
        end
        $display("%0d tests run, %0d passed, %0d failed, %0d check errors",
                 tests_run, tests_run - tests_failed, tests_failed, error_count);
        if (!aborted && error_count == 0 && tests_run > 0 && tests_run == t_op.size()) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* sim/llc_tests.txt */
# op (0 read, 1 write), line address (hex), write data (hex, 128 bits),
# response back-pressure (cycles with ready low after valid)
0 015 00000000000000000000000000000000 0
0 015 00000000000000000000000000000000 1
1 025 a1a1a1a1b2b2b2b2c3c3c3c3d4d4d4d4 0
0 025 00000000000000000000000000000000 2
0 035 00000000000000000000000000000000 0
1 045 0123456789abcdef0fedcba987654321 3
0 055 00000000000000000000000000000000 0
0 065 00000000000000000000000000000000 1
0 025 00000000000000000000000000000000 0
1 075 deadbeef00112233445566778899aabb 2
1 055 5555aaaa5555aaaa5555aaaa5555aaaa 0
0 045 00000000000000000000000000000000 4
1 100 11111111222222223333333344444444 0
0 1a1 00000000000000000000000000000000 0
1 2b2 cafef00d cafef00d cafef00d cafef00d 1
0 3c3 00000000000000000000000000000000 0
1 4d4 0f0f0f0ff0f0f0f00f0f0f0ff0f0f0f0 2
0 5e6 00000000000000000000000000000000 0
1 6f7 77777777666666665555555544444444 0
0 708 00000000000000000000000000000000 1
1 819 13579bdf2468ace013579bdf2468ace0 0
0 92a 00000000000000000000000000000000 0
1 a3b 89abcdef89abcdef89abcdef89abcdef 3
0 b4c 00000000000000000000000000000000 0
1 c5d 00ff00ff00ff00ff00ff00ff00ff00ff 0
0 d6e 00000000000000000000000000000000 2
1 e7f fedcba9876543210fedcba9876543210 0
0 100 00000000000000000000000000000000 0
0 2b2 00000000000000000000000000000000 1
1 1a1 abcdabcdabcdabcdabcdabcdabcdabcd 0
0 1a1 00000000000000000000000000000000 0
1 01a 1a1a1a1a1a1a1a1a1a1a1a1a1a1a1a1a 0
0 11a 00000000000000000000000000000000 2
1 21a 2a2a2a2a2a2a2a2a2a2a2a2a2a2a2a2a 0
0 31a 00000000000000000000000000000000 0
0 41a 00000000000000000000000000000000 1
0 01a 00000000000000000000000000000000 0
1 51a 5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a 0
0 21a 00000000000000000000000000000000 3

/* build.f */
+incdir+logic
logic/llc_pkg.sv
logic/llc_localmem.sv
logic/llc_lookup_way.sv
logic/llc_process_request.sv
logic/llc_core.sv
sim/llc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the LLC testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module llc_tb -o llc_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/llc_sim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
